// ==== include/exec_cfg.svh ====
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// Datapath width in bits
`define EXEC_WIDTH 32

// One quotient or product bit per step
`define EXEC_STEPS 32

// x86 EFLAGS bit positions
`define EFLAGS_CF 0
`define EFLAGS_PF 2
`define EFLAGS_AF 4
`define EFLAGS_ZF 6
`define EFLAGS_SF 7
`define EFLAGS_OF 11

// Positions inside the packed status vector
`define STAT_OF 0
`define STAT_SF 1
`define STAT_ZF 2
`define STAT_PF 3
`define STAT_CF 4
`define STAT_AF 5

`endif

// ==== hdl/exec_pkg.sv ====
`include "exec_cfg.svh"

package exec_pkg;

  // Operand or result word
  typedef logic [`EXEC_WIDTH-1:0] word_t;

  // Full flags register
  typedef logic [31:0] eflags_t;

  // Arithmetic flags, indexed by the STAT positions
  typedef logic [5:0] status_t;

  // Wide enough to hold EXEC_STEPS itself
  typedef logic [$clog2(`EXEC_STEPS):0] step_t;

  // Command codes, numbered in sequence from NOP
  typedef enum logic [5:0] {
    CMD_NOP,
    CMD_ADD,
    CMD_ADC,
    CMD_INC,
    CMD_SUB,
    CMD_SBB,
    CMD_DEC,
    CMD_CMP,
    CMD_CMPS,
    CMD_AND,
    CMD_TEST,
    CMD_OR,
    CMD_XOR,
    CMD_NOT,
    CMD_MUL,
    CMD_IMUL,
    CMD_DIV,
    CMD_IDIV,
    CMD_MOV,
    CMD_LEA,
    CMD_MOVS,
    CMD_MOVSX,
    CMD_MOVZX,
    CMD_XCHG
  } exec_cmd_t;

  // Multi-cycle sequencer states
  typedef enum logic [1:0] {MD_IDLE, MD_RUN, MD_DONE} md_state_t;

endpackage

// ==== hdl/exec_decode.sv ====
module exec_decode
  import exec_pkg::*;
(
  input  exec_cmd_t cmd,
  output logic      is_alu,
  output logic      is_mu,
  output logic      is_md,
  output logic      md_div,
  output logic      op_add,
  output logic      op_sub,
  output logic      op_and,
  output logic      op_or,
  output logic      op_xor,
  output logic      src_inv,
  output logic      use_carry,
  output logic      src_inc,
  output logic      keep_cf,
  output logic      no_wr,
  output logic      no_flags,
  output logic      clear_cf_of,
  output logic      mu_sext,
  output logic      mu_zext
);

  // Core ALU operations
  assign op_add = cmd inside {CMD_ADD, CMD_ADC, CMD_INC};
  assign op_sub = cmd inside {CMD_SUB, CMD_SBB, CMD_DEC, CMD_CMP, CMD_CMPS};
  assign op_and = cmd inside {CMD_AND, CMD_TEST};
  assign op_or  = cmd == CMD_OR;
  // NOT is an XOR against all ones
  assign op_xor = cmd inside {CMD_XOR, CMD_NOT};

  assign is_alu = op_add | op_sub | op_and | op_or | op_xor;

  // Every subtract adds the complement
  assign src_inv   = op_sub;
  assign use_carry = cmd inside {CMD_ADC, CMD_SBB};
  // Constant second operand
  assign src_inc   = cmd inside {CMD_INC, CMD_DEC, CMD_NOT};
  // INC and DEC leave CF alone
  assign keep_cf   = cmd inside {CMD_INC, CMD_DEC};

  // Compare-style commands only touch flags
  assign no_wr       = cmd inside {CMD_CMP, CMD_CMPS, CMD_TEST};
  assign no_flags    = cmd == CMD_NOT;
  assign clear_cf_of = cmd inside {CMD_AND, CMD_OR, CMD_XOR, CMD_TEST};

  // Move unit, LEA counts as a move of the computed address
  assign is_mu   = cmd inside {CMD_MOV, CMD_LEA, CMD_MOVS, CMD_MOVSX, CMD_MOVZX, CMD_XCHG};
  assign mu_sext = cmd == CMD_MOVSX;
  assign mu_zext = cmd == CMD_MOVZX;

  // Multi-cycle unit, signed forms are not handled
  assign is_md  = cmd inside {CMD_MUL, CMD_DIV};
  assign md_div = cmd == CMD_DIV;

  // Units are mutually exclusive
  always_comb begin
    assert ($onehot0({is_alu, is_mu, is_md}));
  end

endmodule

// ==== hdl/exec_alu.sv ====
`include "exec_cfg.svh"

module exec_alu
  import exec_pkg::*;
(
  input  logic    op_add,
  input  logic    op_sub,
  input  logic    op_and,
  input  logic    op_or,
  input  logic    op_xor,
  input  logic    src_inv,
  input  logic    use_carry,
  input  logic    src_inc,
  input  logic    keep_cf,
  input  logic    clear_cf_of,
  input  status_t status_in,
  input  word_t   opnd0_r,
  input  word_t   opnd1_r,
  output status_t status_out,
  output word_t   result
);

  localparam int W = `EXEC_WIDTH;

  word_t          b_src;
  word_t          b_eff;
  word_t          logic_res;
  logic [W:0]     sum;
  logic           cin;
  logic           cf_arith;
  logic           of_arith;
  logic           af_arith;

  // Constant operand is 1, or all ones when NOT
  assign b_src = src_inc ? (op_xor ? '1 : word_t'(1)) : opnd1_r;
  assign b_eff = src_inv ? ~b_src : b_src;

  // SUB adds 1, SBB adds ~CF, ADC adds CF
  assign cin = op_sub ^ (use_carry & status_in[`STAT_CF]);

  assign sum = {1'b0, opnd0_r} + {1'b0, b_eff} + {{W{1'b0}}, cin};

  always_comb begin
    if (op_and) begin
      logic_res = opnd0_r & b_src;
    end else if (op_or) begin
      logic_res = opnd0_r | b_src;
    end else if (op_xor) begin
      logic_res = opnd0_r ^ b_src;
    end else begin
      logic_res = '0;
    end
  end

  assign result = (op_add | op_sub) ? sum[W-1:0] : logic_res;

  // Borrow is the inverted carry out when subtracting
  assign cf_arith = sum[W] ^ op_sub;

  // Same-sign inputs giving a different-sign result
  assign of_arith = (opnd0_r[W-1] == b_eff[W-1]) && (result[W-1] != opnd0_r[W-1]);

  // Carry or borrow into bit 4
  assign af_arith = opnd0_r[4] ^ b_src[4] ^ result[4];

  always_comb begin
    status_out = '0;
    status_out[`STAT_ZF] = result == '0;
    status_out[`STAT_SF] = result[W-1];
    // Even parity of the low byte
    status_out[`STAT_PF] = ~^result[7:0];
    if (clear_cf_of) begin
      status_out[`STAT_CF] = 1'b0;
      status_out[`STAT_OF] = 1'b0;
      status_out[`STAT_AF] = 1'b0;
    end else begin
      status_out[`STAT_CF] = keep_cf ? status_in[`STAT_CF] : cf_arith;
      status_out[`STAT_OF] = of_arith;
      status_out[`STAT_AF] = af_arith;
    end
  end

endmodule

// ==== hdl/exec_step_counter.sv ====
`include "exec_cfg.svh"

module exec_step_counter
  import exec_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  clear,
  input  logic  step,
  output step_t count,
  output logic  last
);

  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      count <= '0;
    end else if (step) begin
      count <= count + step_t'(1);
    end
  end

  // Final step of the sequence
  assign last = step && (count == step_t'(`EXEC_STEPS - 1));

  // Controller never steps in the load cycle
  a_no_step_on_clear: assert property (@(posedge clk) disable iff (!rst_n)
    !(step && clear));

endmodule

// ==== hdl/exec_muldiv_ctrl.sv ====
module exec_muldiv_ctrl
  import exec_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      go,
  input  logic      last,
  output md_state_t state,
  output logic      clear,
  output logic      load,
  output logic      step,
  output logic      md_done
);

  md_state_t state_nxt;

  always_comb begin
    state_nxt = state;
    case (state)
      MD_IDLE: begin
        if (go) begin
          state_nxt = MD_RUN;
        end
      end
      MD_RUN: begin
        // Leave after the final step
        if (last) begin
          state_nxt = MD_DONE;
        end
      end
      MD_DONE: state_nxt = MD_IDLE;
      default: state_nxt = MD_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= MD_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Operand load and counter clear share the go cycle
  assign load    = (state == MD_IDLE) && go;
  assign clear   = load;
  assign step    = state == MD_RUN;
  assign md_done = state == MD_DONE;

  // Top must hold off a new command until the sequence ends
  a_go_idle: assert property (@(posedge clk) disable iff (!rst_n)
    go |-> state == MD_IDLE);

endmodule

// ==== hdl/exec_muldiv_datapath.sv ====
`include "exec_cfg.svh"

module exec_muldiv_datapath
  import exec_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  load,
  input  logic  step,
  input  logic  md_div,
  input  word_t opnd0_r,
  input  word_t opnd1_r,
  output word_t md_result,
  output logic  md_cf_of,
  output logic  div_by_zero
);

  localparam int W = `EXEC_WIDTH;

  // MUL: 64-bit product; DIV: remainder high, quotient low
  logic [2*W-1:0] acc;
  // MUL: shifted multiplicand; DIV: divisor in the low half
  logic [2*W-1:0] mcand;
  word_t          mplier;
  logic [W:0]     rem_sh;
  logic [W+1:0]   trial;

  // Partial remainder after the left shift
  assign rem_sh = acc[2*W-1:W-1];
  assign trial  = {1'b0, rem_sh} - {2'b00, mcand[W-1:0]};

  always_ff @(posedge clk) begin
    if (load) begin
      acc    <= md_div ? {{W{1'b0}}, opnd0_r} : '0;
      mcand  <= {{W{1'b0}}, (md_div ? opnd1_r : opnd0_r)};
      mplier <= opnd1_r;
    end else if (step) begin
      if (md_div) begin
        // Keep the difference only when there is no borrow
        if (!trial[W+1]) begin
          acc <= {trial[W-1:0], acc[W-2:0], 1'b1};
        end else begin
          acc <= {acc[2*W-2:0], 1'b0};
        end
      end else begin
        if (mplier[0]) begin
          acc <= acc + mcand;
        end
        mcand  <= mcand << 1;
        mplier <= mplier >> 1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      div_by_zero <= 1'b0;
    end else if (load) begin
      div_by_zero <= md_div && (opnd1_r == '0);
    end
  end

  // Quotient and low product share the low half
  assign md_result = div_by_zero ? '1 : acc[W-1:0];
  // High product half lost
  assign md_cf_of  = !md_div && (acc[2*W-1:W] != '0);

endmodule

// ==== hdl/exec_writeback.sv ====
`include "exec_cfg.svh"

module exec_writeback
  import exec_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    fire,
  input  logic    md_done,
  input  logic    is_alu,
  input  logic    is_mu,
  input  logic    is_md,
  input  logic    md_div,
  input  logic    no_wr,
  input  logic    no_flags,
  input  logic    mu_sext,
  input  logic    mu_zext,
  input  eflags_t eflags,
  input  word_t   opnd1_r,
  input  word_t   alu_result,
  input  status_t alu_status,
  input  word_t   md_result,
  input  logic    md_cf_of,
  output word_t   opnd0_w,
  output eflags_t o_eflags,
  output logic    wr_en,
  output logic    done
);

  logic    wb_now;
  word_t   mu_result;
  word_t   result;
  eflags_t alu_eflags;
  eflags_t mul_eflags;
  eflags_t new_eflags;

  // Single-cycle commands retire right after the latch
  assign wb_now = (fire && !is_md) || md_done;

  // Move unit with 16-bit source extension
  assign mu_result = mu_sext ? {{16{opnd1_r[15]}}, opnd1_r[15:0]} :
                     mu_zext ? {16'b0, opnd1_r[15:0]} : opnd1_r;

  assign result = is_alu ? alu_result :
                  is_mu  ? mu_result  :
                  is_md  ? md_result  : '0;

  always_comb begin
    alu_eflags = eflags;
    alu_eflags[`EFLAGS_CF] = alu_status[`STAT_CF];
    alu_eflags[`EFLAGS_PF] = alu_status[`STAT_PF];
    alu_eflags[`EFLAGS_AF] = alu_status[`STAT_AF];
    alu_eflags[`EFLAGS_ZF] = alu_status[`STAT_ZF];
    alu_eflags[`EFLAGS_SF] = alu_status[`STAT_SF];
    alu_eflags[`EFLAGS_OF] = alu_status[`STAT_OF];
    // MUL only reports an overflowed high half
    mul_eflags = eflags;
    mul_eflags[`EFLAGS_CF] = md_cf_of;
    mul_eflags[`EFLAGS_OF] = md_cf_of;
  end

  // DIV, moves and no-ops pass flags through
  assign new_eflags = (is_alu && !no_flags) ? alu_eflags :
                      (is_md && !md_div)    ? mul_eflags : eflags;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      opnd0_w  <= '0;
      o_eflags <= '0;
      wr_en    <= 1'b0;
      done     <= 1'b0;
    end else begin
      done <= wb_now;
      // Hold until the next command retires
      if (wb_now) begin
        opnd0_w  <= result;
        o_eflags <= new_eflags;
        wr_en    <= (is_alu && !no_wr) || is_mu || is_md;
      end
    end
  end

endmodule

// ==== hdl/exec_top.sv ====
`include "exec_cfg.svh"

module exec_top
  import exec_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      start,
  input  exec_cmd_t opc,
  input  eflags_t   eflags,
  input  word_t     opnd0_r,
  input  word_t     opnd1_r,
  output logic      done,
  output logic      busy,
  output logic      wr_en,
  output word_t     opnd0_w,
  output eflags_t   o_eflags
);

  exec_cmd_t opc_q;
  eflags_t   eflags_q;
  word_t     opnd0_q;
  word_t     opnd1_q;
  logic      fire;
  logic      accept;
  logic      go;
  status_t   status_in;
  status_t   alu_status;
  word_t     alu_result;
  word_t     md_result;
  logic      md_cf_of;
  logic      div_by_zero;
  md_state_t md_state;
  step_t     step_count;
  logic      md_clear;
  logic      md_load;
  logic      md_step;
  logic      md_last;
  logic      md_done;
  logic is_alu, is_mu, is_md, md_div;
  logic op_add, op_sub, op_and, op_or, op_xor;
  logic src_inv, use_carry, src_inc, keep_cf;
  logic no_wr, no_flags, clear_cf_of, mu_sext, mu_zext;

  // Starts during a running command are dropped
  assign accept = start && !busy;
  assign go     = fire && is_md;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy  <= 1'b0;
      fire  <= 1'b0;
      opc_q <= CMD_NOP;
    end else begin
      fire <= accept;
      if (accept) begin
        busy  <= 1'b1;
        opc_q <= opc;
      end else if ((fire && !is_md) || md_done) begin
        // Drops on the same edge that raises done
        busy <= 1'b0;
      end
    end
  end

  // Instruction operands
  always_ff @(posedge clk) begin
    if (accept) begin
      eflags_q <= eflags;
      opnd0_q  <= opnd0_r;
      opnd1_q  <= opnd1_r;
    end
  end

  // Arithmetic flags into the ALU
  assign status_in[`STAT_CF] = eflags_q[`EFLAGS_CF];
  assign status_in[`STAT_PF] = eflags_q[`EFLAGS_PF];
  assign status_in[`STAT_AF] = eflags_q[`EFLAGS_AF];
  assign status_in[`STAT_ZF] = eflags_q[`EFLAGS_ZF];
  assign status_in[`STAT_SF] = eflags_q[`EFLAGS_SF];
  assign status_in[`STAT_OF] = eflags_q[`EFLAGS_OF];

  exec_decode exec_decode_inst (
    .cmd(opc_q), .is_alu(is_alu), .is_mu(is_mu), .is_md(is_md), .md_div(md_div),
    .op_add(op_add), .op_sub(op_sub), .op_and(op_and), .op_or(op_or), .op_xor(op_xor),
    .src_inv(src_inv), .use_carry(use_carry), .src_inc(src_inc), .keep_cf(keep_cf),
    .no_wr(no_wr), .no_flags(no_flags), .clear_cf_of(clear_cf_of),
    .mu_sext(mu_sext), .mu_zext(mu_zext)
  );

  exec_alu exec_alu_inst (
    .op_add(op_add), .op_sub(op_sub), .op_and(op_and), .op_or(op_or), .op_xor(op_xor),
    .src_inv(src_inv), .use_carry(use_carry), .src_inc(src_inc), .keep_cf(keep_cf),
    .clear_cf_of(clear_cf_of), .status_in(status_in), .opnd0_r(opnd0_q),
    .opnd1_r(opnd1_q), .status_out(alu_status), .result(alu_result)
  );

  exec_muldiv_ctrl exec_muldiv_ctrl_inst (
    .clk(clk), .rst_n(rst_n), .go(go), .last(md_last), .state(md_state),
    .clear(md_clear), .load(md_load), .step(md_step), .md_done(md_done)
  );

  exec_step_counter exec_step_counter_inst (
    .clk(clk), .rst_n(rst_n), .clear(md_clear), .step(md_step),
    .count(step_count), .last(md_last)
  );

  exec_muldiv_datapath exec_muldiv_datapath_inst (
    .clk(clk), .rst_n(rst_n), .load(md_load), .step(md_step), .md_div(md_div),
    .opnd0_r(opnd0_q), .opnd1_r(opnd1_q), .md_result(md_result),
    .md_cf_of(md_cf_of), .div_by_zero(div_by_zero)
  );

  exec_writeback exec_writeback_inst (
    .clk(clk), .rst_n(rst_n), .fire(fire), .md_done(md_done), .is_alu(is_alu),
    .is_mu(is_mu), .is_md(is_md), .md_div(md_div), .no_wr(no_wr), .no_flags(no_flags),
    .mu_sext(mu_sext), .mu_zext(mu_zext), .eflags(eflags_q), .opnd1_r(opnd1_q),
    .alu_result(alu_result), .alu_status(alu_status), .md_result(md_result),
    .md_cf_of(md_cf_of), .opnd0_w(opnd0_w), .o_eflags(o_eflags), .wr_en(wr_en),
    .done(done)
  );

  // Every sequence runs the full step count
  a_full_steps: assert property (@(posedge clk) disable iff (!rst_n)
    md_state == MD_DONE |-> step_count == step_t'(`EXEC_STEPS));

  // Divide by zero retires with flags untouched
  a_dbz_flags: assert property (@(posedge clk) disable iff (!rst_n)
    md_done && div_by_zero |=> o_eflags == eflags_q);

endmodule

// ==== tests/exec_tb.sv ====
`include "exec_cfg.svh"

module exec_tb
  import exec_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT_CYCLES = 100;
  // Retire latency in clock edges, counted from the edge that samples start
  localparam int LAT_SINGLE = 2;
  localparam int LAT_MULTI  = `EXEC_STEPS + 3;

  logic      clk;
  logic      rst_n;
  logic      start;
  exec_cmd_t opc;
  eflags_t   eflags;
  word_t     opnd0_r;
  word_t     opnd1_r;
  logic      done;
  logic      busy;
  logic      wr_en;
  word_t     opnd0_w;
  eflags_t   o_eflags;

  int          test_errors;
  int          pass_count;
  int          fail_count;
  logic [31:0] rng_state;

  exec_top exec_top_inst (
    .clk(clk), .rst_n(rst_n), .start(start), .opc(opc), .eflags(eflags),
    .opnd0_r(opnd0_r), .opnd1_r(opnd1_r), .done(done), .busy(busy),
    .wr_en(wr_en), .opnd0_w(opnd0_w), .o_eflags(o_eflags)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("error %s: opnd0_w expected %h actual %h", name, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_eflags(input string name, input eflags_t exp, input eflags_t act);
    if (act !== exp) begin
      $display("error %s: o_eflags expected %h actual %h", name, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_wr(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("error %s: wr_en expected %b actual %b", name, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_busy(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("error %s: busy expected %b actual %b", name, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("error %s: latency expected %0d actual %0d", name, exp, act);
      test_errors++;
    end
  endtask

  // One instruction from start to done, then compare
  task automatic run_vector(input string name, input exec_cmd_t cmd, input eflags_t flags_in,
                            input word_t a, input word_t b, input word_t exp_res,
                            input eflags_t exp_flags, input logic exp_wr);
    int         edges;
    int         inject_at;
    logic       multi;
    logic       busy_run;
    logic [5:0] junk_op;

    test_errors = 0;
    busy_run = 1'b1;
    multi = (cmd == CMD_MUL) || (cmd == CMD_DIV);
    rng_state = xorshift32(rng_state);
    inject_at = 3 + int'(rng_state % 32'd28);
    opc     = cmd;
    eflags  = flags_in;
    opnd0_r = a;
    opnd1_r = b;
    start   = 1'b1;
    @(negedge clk);
    start = 1'b0;
    edges = 1;
    while (done !== 1'b1 && edges < TIMEOUT_CYCLES) begin
      // Busy from the latch until done, first bad value kept
      if (busy !== 1'b1 && busy_run === 1'b1) begin
        busy_run = busy;
      end
      if (multi && edges == inject_at) begin
        // Competing command during MUL/DIV, the DUT has to drop it
        rng_state = xorshift32(rng_state);
        junk_op   = rng_state[5:0] % 6'd24;
        opc       = exec_cmd_t'(junk_op);
        opnd0_r   = rng_state;
        opnd1_r   = ~rng_state;
        start     = 1'b1;
      end else begin
        start = 1'b0;
      end
      @(negedge clk);
      edges++;
    end
    start = 1'b0;
    if (done !== 1'b1) begin
      $display("%s: done never came within %0d cycles of start", name, TIMEOUT_CYCLES);
      test_errors++;
    end else begin
      check_latency(name, multi ? LAT_MULTI : LAT_SINGLE, edges);
      check_busy(name, 1'b1, busy_run);
      // Busy drops on the edge that raises done
      check_busy(name, 1'b0, busy);
      check_word(name, exp_res, opnd0_w);
      check_eflags(name, exp_flags, o_eflags);
      check_wr(name, exp_wr, wr_en);
    end
    if (test_errors == 0) begin
      pass_count++;
      $display("%s: pass", name);
    end else begin
      fail_count++;
      $display("%s: fail", name);
    end
  endtask

  initial begin
    int          fd;
    int          fields;
    string       line;
    string       name;
    logic [31:0] v_opc;
    logic [31:0] v_flags;
    logic [31:0] v_a;
    logic [31:0] v_b;
    logic [31:0] v_res;
    logic [31:0] v_exp_flags;
    logic [31:0] v_wr;

    rst_n       = 1'b0;
    start       = 1'b0;
    opc         = CMD_NOP;
    eflags      = '0;
    opnd0_r     = '0;
    opnd1_r     = '0;
    test_errors = 0;
    pass_count  = 0;
    fail_count  = 0;
    rng_state   = 32'hae1e0b29;
    // Reset held for 3 cycles, released on a falling edge
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    fd = $fopen("tests/exec_input.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file tests/exec_input.txt");
      fail_count++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        // Blank and comment lines
        if (line.len() < 2 || line.getc(0) == "#") begin
          continue;
        end
        fields = $sscanf(line, "%s %h %h %h %h %h %h %h", name, v_opc, v_flags, v_a, v_b,
                         v_res, v_exp_flags, v_wr);
        if (fields != 8) begin
          $display("vector line could not be parsed: %s", line);
          fail_count++;
        end else begin
          run_vector(name, exec_cmd_t'(v_opc[5:0]), v_flags, v_a, v_b, v_res,
                     v_exp_flags, v_wr[0]);
        end
      end
      $fclose(fd);
    end

    $display("%0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0 && pass_count > 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+include
hdl/exec_pkg.sv
hdl/exec_decode.sv
hdl/exec_alu.sv
hdl/exec_step_counter.sv
hdl/exec_muldiv_ctrl.sv
hdl/exec_muldiv_datapath.sv
hdl/exec_writeback.sv
hdl/exec_top.sv
tests/exec_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the execute-stage testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module exec_tb -f build.f

./obj_dir/Vexec_tb 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
echo "simulation finished without failures"

// ==== tests/exec_input.txt ====
# name opc eflags opnd0_r opnd1_r exp_opnd0_w exp_o_eflags exp_wr_en
# All numbers hex, opc in exec_cmd_t order (NOP=00 ... XCHG=17)
add_basic        01 00000002 00000001 00000002 00000003 00000006 1
add_carry        01 00000002 ffffffff 00000001 00000000 00000057 1
add_overflow     01 00000002 7fffffff 00000001 80000000 00000896 1
adc_carry_in     02 00000003 00000010 00000020 00000031 00000002 1
adc_wrap         02 00000003 ffffffff 00000000 00000000 00000057 1
sub_basic        04 00000002 00000005 00000003 00000002 00000002 1
sub_borrow       04 00000002 00000000 00000001 ffffffff 00000097 1
sub_overflow     04 00000002 80000000 00000001 7fffffff 00000816 1
sbb_borrow_in    05 00000003 00000010 00000010 ffffffff 00000097 1
inc_keep_cf      03 00000003 0000000f 12345678 00000010 00000013 1
inc_overflow     03 00000002 7fffffff 00000000 80000000 00000896 1
dec_zero_keep_cf 06 00000003 00000001 00000000 00000000 00000047 1
dec_wrap         06 00000002 00000000 00000000 ffffffff 00000096 1
cmp_equal        07 00000002 12345678 12345678 00000000 00000046 0
cmps_less        08 00000002 00000001 00000002 ffffffff 00000097 0
and_clear        09 000008d7 f0f0f0f0 0f0f0f0f 00000000 00000046 1
test_flags       0a 000008d7 80000081 800000ff 80000081 00000086 0
or_basic         0b 00000813 00000100 00000003 00000103 00000006 1
xor_basic        0c 00000002 a5a5a5a5 5a5a5a5a ffffffff 00000086 1
not_keep_flags   0d 000008d7 0000ffff 00000000 ffff0000 000008d7 1
mov_pass         12 000000c3 11111111 deadbeef deadbeef 000000c3 1
lea_pass         13 00000002 00000000 00401000 00401000 00000002 1
movs_pass        14 00000803 00000000 c0ffee00 c0ffee00 00000803 1
xchg_pass        17 000008d7 aaaaaaaa 55555555 55555555 000008d7 1
movsx_neg        15 00000002 00000000 12348001 ffff8001 00000002 1
movsx_pos        15 00000002 00000000 abcd7fff 00007fff 00000002 1
movzx_neg        16 00000002 00000000 1234f00f 0000f00f 00000002 1
mul_small        0e 00000803 00001234 00000100 00123400 00000002 1
mul_overflow     0e 00000002 00010000 00010001 00010000 00000803 1
mul_max          0e 00000002 ffffffff ffffffff 00000001 00000803 1
div_basic        10 000000c3 00000064 00000007 0000000e 000000c3 1
div_big          10 00000002 ffffffff 00000010 0fffffff 00000002 1
div_zero         10 000008d7 12345678 00000000 ffffffff 000008d7 1
imul_nop         0f 000008d7 00000005 00000006 00000000 000008d7 0
idiv_nop         11 00000002 00000064 00000007 00000000 00000002 0
nop              00 000000c3 ffffffff ffffffff 00000000 000000c3 0
